//--- include/dispatch_ref.svh
`ifndef DISPATCH_REF_SVH
`define DISPATCH_REF_SVH

// mirror of the active cpu set and the thread table
bit [CPU_NUM-1:0]  ref_active;
bit [THRD_NUM-1:0] ref_vld;
logic [ADDR_W-1:0] ref_tbl [THRD_NUM];
// last handed-out indices
int ref_last_cpu;
int ref_last_thrd;

function automatic void ref_reset();
  ref_active = '0;
  ref_vld = '0;
  // top index, so index 0 is tried first
  ref_last_cpu = CPU_NUM - 1;
  ref_last_thrd = THRD_NUM - 1;
endfunction

// next cpu and next thread after the last taken ones
function automatic bit ref_next_pair(output int cpu, output int tidx);
  bit cpu_ok;
  bit thrd_ok;
  int c;
  int t;
  cpu_ok = 1'b0;
  thrd_ok = 1'b0;
  cpu = 0;
  tidx = 0;
  for (int i = 1; i <= CPU_NUM; i++) begin
    c = (ref_last_cpu + i) % CPU_NUM;
    if (!cpu_ok && ref_active[c]) begin
      cpu_ok = 1'b1;
      cpu = c;
    end
  end
  for (int i = 1; i <= THRD_NUM; i++) begin
    t = (ref_last_thrd + i) % THRD_NUM;
    if (!thrd_ok && ref_vld[t]) begin
      thrd_ok = 1'b1;
      tidx = t;
    end
  end
  return cpu_ok && thrd_ok;
endfunction

// applies one message, returns 1 for a fork into a full table
function automatic bit ref_message(cpu_msg_e code, int cpu, logic [ADDR_W-1:0] addr);
  bit full;
  full = 1'b1;
  case (code)
    MSG_START: ref_active[cpu] = 1'b1;
    MSG_END:   ref_active[cpu] = 1'b0;
    MSG_FORK: begin
      // lowest free entry wins
      for (int i = 0; i < THRD_NUM; i++) begin
        if (full && !ref_vld[i]) begin
          ref_vld[i] = 1'b1;
          ref_tbl[i] = addr;
          full = 1'b0;
        end
      end
    end
    MSG_STOP: begin
      for (int i = 0; i < THRD_NUM; i++) begin
        if (ref_vld[i] && ref_tbl[i] == addr) begin
          ref_vld[i] = 1'b0;
        end
      end
    end
    default: ;
  endcase
  return (code == MSG_FORK) && full;
endfunction

`endif

//--- dv/tb_dispatcher.sv
module tb_dispatcher import dispatch_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // rough cycle budget per stimulus phase
  localparam int SETUP_CYC = 30;
  localparam int ORDER_CYC = 20;
  localparam int RAND_CYC = 60;
  localparam int REMOVE_CYC = 40;
  localparam int MEM_CYC = 60;
  localparam int TIMEOUT_CYC = (SETUP_CYC * 2 + ORDER_CYC + RAND_CYC + REMOVE_CYC + MEM_CYC) * 4
                               + 50;
  localparam int PAIR_CNT = 12;
  localparam int MEM_CNT = 6;

  logic                 clk;
  logic                 ext_rst_e;
  logic                 msg_valid;
  logic [CPU_IDX_W-1:0] msg_cpu;
  cpu_msg_e             msg_code;
  logic [ADDR_W-1:0]    msg_addr;
  logic                 msg_ready;
  logic                 dsp_valid;
  logic [CPU_IDX_W-1:0] dsp_cpu;
  logic [ADDR_W-1:0]    dsp_addr;
  logic                 dsp_ready;
  logic                 fork_full;
  logic                 mem_valid;
  logic                 mem_we;
  logic [ADDR_W-1:0]    mem_addr;
  logic [DATA_W-1:0]    mem_wdata;
  logic                 mem_ready;
  logic                 rsp_valid;
  logic [DATA_W-1:0]    rsp_rdata;
  logic                 rsp_ready;

  `include "dispatch_ref.svh"

  // model of the dispatch slot
  bit                   slot_full;
  logic [CPU_IDX_W-1:0] slot_cpu;
  logic [ADDR_W-1:0]    slot_addr;
  bit                   exp_ff;
  bit                   rsp_pend;
  bit                   seen_rst;
  logic [DATA_W-1:0]    mem_ref [MEM_DEPTH];
  logic [DATA_W-1:0]    exp_rsp [$];
  // accepted pairs, cpu in the upper bits
  logic [CPU_IDX_W+ADDR_W-1:0] acc_q [$];
  // model pairs at each accept
  logic [CPU_IDX_W+ADDR_W-1:0] exp_q [$];
  logic [CPU_IDX_W+ADDR_W-1:0] seq_ref [$];
  int acc_count;
  int ff_seen;
  int read_count;
  int rsp_count;
  int errors;
  int cycles;
  // 0 low, 1 high, 2 random
  int dsp_mode;
  bit rsp_rand;
  logic [15:0] lfsr;

  dispatcher_of_cpus dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // fibonacci lfsr, taps 16 14 13 11
  function automatic bit lfsr_bit();
    bit fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [ADDR_W-1:0] thread_addr(int i);
    return 16'h2000 + ADDR_W'(i * 'h40);
  endfunction

  task automatic report_mismatch(string sig, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
    $display("Mismatch at %0d ns: %s got 'h%0h expected 'h%0h", $time, sig, got, exp);
    errors++;
  endtask

  task automatic report_failure(string what);
    $display("Error at %0d ns: %s", $time, what);
    errors++;
  endtask

  // ready lines, one bit per draw
  always @(posedge clk) begin
    case (dsp_mode)
      0: dsp_ready <= 1'b0;
      1: dsp_ready <= 1'b1;
      default: dsp_ready <= lfsr_bit();
    endcase
    if (rsp_rand) begin
      rsp_ready <= lfsr_bit();
    end else begin
      rsp_ready <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYC) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Done: errors found");
      $finish;
    end
  end

  // compare at the falling edge, where inputs and outputs are settled
  always @(negedge clk) begin
    int cpu;
    int tidx;
    int widx;
    bit take;
    if (ext_rst_e) begin
      if (msg_ready !== 1'b0) begin
        report_mismatch("msg_ready", DATA_W'(msg_ready), DATA_W'(1'b0));
      end
      ref_reset();
      slot_full = 1'b0;
      exp_ff = 1'b0;
      rsp_pend = 1'b0;
      exp_rsp.delete();
      seen_rst = 1'b1;
    end else if (seen_rst) begin
      if (msg_ready !== 1'b1) begin
        report_mismatch("msg_ready", DATA_W'(msg_ready), DATA_W'(1'b1));
      end
      if (fork_full !== exp_ff) begin
        report_mismatch("fork_full", DATA_W'(fork_full), DATA_W'(exp_ff));
      end
      if (fork_full) begin
        ff_seen++;
      end
      // held pair must match the one loaded
      if (dsp_valid !== slot_full) begin
        report_mismatch("dsp_valid", DATA_W'(dsp_valid), DATA_W'(slot_full));
      end else if (slot_full) begin
        if (dsp_cpu !== slot_cpu) begin
          report_mismatch("dsp_cpu", DATA_W'(dsp_cpu), DATA_W'(slot_cpu));
        end
        if (dsp_addr !== slot_addr) begin
          report_mismatch("dsp_addr", DATA_W'(dsp_addr), DATA_W'(slot_addr));
        end
      end
      if (dsp_valid && dsp_ready) begin
        acc_q.push_back({dsp_cpu, dsp_addr});
        exp_q.push_back({slot_cpu, slot_addr});
        acc_count++;
      end
      // slot refill for the coming edge
      take = (!slot_full || dsp_ready) && ref_next_pair(cpu, tidx);
      if (take) begin
        slot_cpu = CPU_IDX_W'(cpu);
        slot_addr = ref_tbl[tidx];
        slot_full = 1'b1;
        ref_last_cpu = cpu;
        ref_last_thrd = tidx;
      end else if (dsp_ready) begin
        slot_full = 1'b0;
      end
      exp_ff = msg_valid ? ref_message(msg_code, int'(msg_cpu), msg_addr) : 1'b0;
      // memory side
      if (rsp_valid !== rsp_pend) begin
        report_mismatch("rsp_valid", DATA_W'(rsp_valid), DATA_W'(rsp_pend));
      end
      if (mem_ready !== !(rsp_pend && !rsp_ready)) begin
        report_mismatch("mem_ready", DATA_W'(mem_ready), DATA_W'(!(rsp_pend && !rsp_ready)));
      end
      if (rsp_valid && rsp_ready) begin
        if (exp_rsp.size() == 0) begin
          report_failure("read response without an outstanding read");
        end else if (rsp_rdata !== exp_rsp[0]) begin
          report_mismatch("rsp_rdata", rsp_rdata, exp_rsp[0]);
          void'(exp_rsp.pop_front());
        end else begin
          void'(exp_rsp.pop_front());
        end
        rsp_count++;
      end
      if (rsp_ready) begin
        rsp_pend = 1'b0;
      end
      if (mem_valid && mem_ready) begin
        widx = int'(mem_addr) % MEM_DEPTH;
        if (mem_we) begin
          mem_ref[widx] = mem_wdata;
        end else begin
          exp_rsp.push_back(mem_ref[widx]);
          read_count++;
          rsp_pend = 1'b1;
        end
      end
    end
  end

  task automatic do_reset();
    @(posedge clk);
    ext_rst_e <= 1'b1;
    repeat (2) @(posedge clk);
    ext_rst_e <= 1'b0;
  endtask

  // one message, valid for a single cycle
  task automatic send_msg(cpu_msg_e code, logic [CPU_IDX_W-1:0] cpu, logic [ADDR_W-1:0] addr);
    @(posedge clk);
    msg_valid <= 1'b1;
    msg_code <= code;
    msg_cpu <= cpu;
    msg_addr <= addr;
    @(posedge clk);
    msg_valid <= 1'b0;
    msg_code <= MSG_NONE;
  endtask

  task automatic mem_req(logic we, logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] data);
    @(posedge clk);
    mem_valid <= 1'b1;
    mem_we <= we;
    mem_addr <= addr;
    mem_wdata <= data;
    @(negedge clk);
    while (!mem_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    mem_valid <= 1'b0;
  endtask

  task automatic wait_accepts(int n);
    int target;
    target = acc_count + n;
    while (acc_count < target) begin
      @(negedge clk);
    end
  endtask

  // reset, threads without cpus, then three cpus
  task automatic setup_threads_and_cpus();
    do_reset();
    @(negedge clk);
    if (dsp_valid || rsp_valid) begin
      report_failure("dsp_valid or rsp_valid high after reset");
    end
    for (int i = 0; i < 5; i++) begin
      send_msg(MSG_FORK, '0, thread_addr(i));
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    if (dsp_valid) begin
      report_failure("dispatch offered with no active cpu");
    end
    send_msg(MSG_START, 2'd0, '0);
    send_msg(MSG_START, 2'd1, '0);
    send_msg(MSG_START, 2'd3, '0);
  endtask

  initial begin
    int start;
    logic [ADDR_W-1:0] a;
    lfsr = 16'd70;
    ext_rst_e = 1'b1;
    msg_valid = 1'b0;
    msg_cpu = '0;
    msg_code = MSG_NONE;
    msg_addr = '0;
    dsp_ready = 1'b0;
    mem_valid = 1'b0;
    mem_we = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    rsp_ready = 1'b1;
    dsp_mode = 0;
    rsp_rand = 1'b0;

    // round-robin order with dsp_ready held high
    setup_threads_and_cpus();
    dsp_mode <= 1;
    start = acc_count;
    wait_accepts(PAIR_CNT);
    dsp_mode = 0;
    for (int k = 0; k < PAIR_CNT; k++) begin
      seq_ref.push_back(exp_q[start + k]);
    end

    // same setup again, random back-pressure
    setup_threads_and_cpus();
    dsp_mode <= 2;
    start = acc_count;
    wait_accepts(PAIR_CNT);
    dsp_mode = 0;
    for (int k = 0; k < PAIR_CNT; k++) begin
      if (acc_q[start + k] !== seq_ref[k]) begin
        report_mismatch("accepted pair", DATA_W'(acc_q[start + k]), DATA_W'(seq_ref[k]));
      end
    end

    // removal and a full thread table, sent while the slot is held
    repeat (2) @(posedge clk);
    start = ff_seen;
    send_msg(MSG_END, 2'd1, '0);
    send_msg(MSG_STOP, '0, thread_addr(2));
    send_msg(MSG_STOP, '0, 16'hdead);
    for (int i = 5; i < 9; i++) begin
      send_msg(MSG_FORK, '0, thread_addr(i));
    end
    // ninth live thread, table is full
    send_msg(MSG_FORK, '0, thread_addr(9));
    repeat (2) @(posedge clk);
    if (ff_seen != start + 1) begin
      report_failure("fork into a full table did not pulse fork_full once");
    end
    dsp_mode <= 1;
    wait_accepts(10);
    dsp_mode = 0;

    // memory writes then reads under random rsp_ready
    rsp_rand = 1'b1;
    for (int i = 0; i < MEM_CNT; i++) begin
      a = 16'h0103 + ADDR_W'(i * 'h1011);
      mem_req(1'b1, a, {a, ~a});
    end
    for (int i = 0; i < MEM_CNT; i++) begin
      a = 16'h0103 + ADDR_W'(i * 'h1011);
      mem_req(1'b0, a, '0);
    end
    while (rsp_count < read_count || exp_rsp.size() != 0) begin
      @(negedge clk);
    end
    rsp_rand = 1'b0;
    repeat (3) @(posedge clk);
    if (read_count != MEM_CNT || rsp_count != MEM_CNT) begin
      report_failure("read and response counts differ from the reads issued");
    end

    $display("errors: %0d  pairs accepted: %0d  reads: %0d  responses: %0d",
             errors, acc_count, read_count, rsp_count);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module tb_dispatcher \
  -o sim_dispatcher

./obj_dir/sim_dispatcher > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
grep -q "Done: no errors" sim.log

//--- src/cpu_slot_sched.sv
module cpu_slot_sched import dispatch_pkg::*; (
  input  logic                 clk,
  input  logic                 ext_rst_e,
  // message port, only start/end decoded here
  input  logic                 msg_valid,
  input  logic [CPU_IDX_W-1:0] msg_cpu,
  input  cpu_msg_e             msg_code,
  // handshake towards dispatch_ctl
  input  logic                 sched_take,
  output logic                 sched_valid,
  output logic [CPU_IDX_W-1:0] sched_cpu
);

  // one bit per cpu, set while the cpu is running
  logic [CPU_NUM-1:0] active;
  // index handed out last, search starts just above it
  logic [CPU_IDX_W-1:0] last_cpu;

  // active set update
  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      active <= '0;
    end else if (msg_valid) begin
      if (msg_code == MSG_START) begin
        active[msg_cpu] <= 1'b1;
      end
      if (msg_code == MSG_END) begin
        active[msg_cpu] <= 1'b0;
      end
    end
  end

  // round-robin pointer
  // top index after reset so cpu 0 is tried first
  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      last_cpu <= CPU_IDX_W'(CPU_NUM - 1);
    end else if (sched_take) begin
      last_cpu <= sched_cpu;
    end
  end

  // search from last_cpu+1 around to last_cpu itself
  // walk the offsets downwards, so the nearest hit is written last
  always_comb begin
    logic [CPU_IDX_W-1:0] idx;
    sched_valid = 1'b0;
    sched_cpu = '0;
    for (int i = CPU_NUM; i >= 1; i--) begin
      // CPU_NUM is a power of two, the sum wraps by itself
      idx = last_cpu + CPU_IDX_W'(i);
      if (active[idx]) begin
        sched_valid = 1'b1;
        sched_cpu = idx;
      end
    end
  end

  // controller must only take an offered cpu
  a_take_needs_valid: assert property (
    @(posedge clk) disable iff (ext_rst_e)
    sched_take |-> sched_valid
  );

endmodule

//--- src/dispatch_ctl.sv
module dispatch_ctl import dispatch_pkg::*; (
  input  logic                 clk,
  input  logic                 ext_rst_e,
  // scheduler side
  input  logic                 sched_valid,
  input  logic [CPU_IDX_W-1:0] sched_cpu,
  output logic                 sched_take,
  // thread manager side
  input  logic                 thrd_valid,
  input  logic [ADDR_W-1:0]    thrd_addr,
  output logic                 thrd_take,
  // dispatch port
  output logic                 dsp_valid,
  output logic [CPU_IDX_W-1:0] dsp_cpu,
  output logic [ADDR_W-1:0]    dsp_addr,
  input  logic                 dsp_ready
);

  ctl_state_e slot_st;
  logic slot_free;
  logic load;

  // slot can be refilled when empty or leaving this cycle
  assign slot_free = (slot_st == SLOT_EMPTY) || dsp_ready;

  // join: both sources must offer at once
  assign load = slot_free && sched_valid && thrd_valid;

  // take pulses go out together
  assign sched_take = load;
  assign thrd_take = load;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      slot_st <= SLOT_EMPTY;
    end else begin
      case (slot_st)
        SLOT_EMPTY: begin
          if (load) begin
            slot_st <= SLOT_FULL;
          end
        end
        SLOT_FULL: begin
          // accepted and nothing to refill with
          if (dsp_ready && !load) begin
            slot_st <= SLOT_EMPTY;
          end
        end
        default: slot_st <= SLOT_EMPTY;
      endcase
    end
  end

  // pair is frozen at load time, later messages do not touch it
  always_ff @(posedge clk) begin
    if (load) begin
      dsp_cpu <= sched_cpu;
      dsp_addr <= thrd_addr;
    end
  end

  assign dsp_valid = (slot_st == SLOT_FULL);

  // held pair under back-pressure
  a_pair_stable: assert property (
    @(posedge clk) disable iff (ext_rst_e)
    dsp_valid && !dsp_ready |=> dsp_valid && $stable(dsp_cpu) && $stable(dsp_addr)
  );

  // a take offers the taken pair on the next cycle
  a_take_loads: assert property (
    @(posedge clk) disable iff (ext_rst_e)
    sched_take |=> dsp_valid && (dsp_cpu == $past(sched_cpu))
                   && (dsp_addr == $past(thrd_addr))
  );

endmodule

//--- src/dispatch_pkg.sv
package dispatch_pkg;

  // cpu slots seen by the scheduler
  localparam int CPU_NUM = 4;
  localparam int CPU_IDX_W = 2;

  // runnable thread table
  localparam int THRD_NUM = 8;
  localparam int THRD_IDX_W = 3;

  // code address and memory address share one width
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // word memory, indexed by low address bits only
  localparam int MEM_DEPTH = 256;
  localparam int MEM_IDX_W = $clog2(MEM_DEPTH);

  // message codes on the cpu message port
  // start/end go to the scheduler, fork/stop to the thread manager
  typedef enum logic [7:0] {
    MSG_NONE  = 8'h00,
    MSG_START = 8'h01,
    MSG_END   = 8'h02,
    MSG_FORK  = 8'h03,
    MSG_STOP  = 8'h04
  } cpu_msg_e;

  // dispatch output register occupancy
  typedef enum logic {
    SLOT_EMPTY = 1'b0,
    SLOT_FULL  = 1'b1
  } ctl_state_e;

endpackage

//--- src/dispatcher_of_cpus.sv
module dispatcher_of_cpus import dispatch_pkg::*; (
  input  logic                 clk,
  input  logic                 ext_rst_e,
  // cpu messages
  input  logic                 msg_valid,
  input  logic [CPU_IDX_W-1:0] msg_cpu,
  input  cpu_msg_e             msg_code,
  input  logic [ADDR_W-1:0]    msg_addr,
  output logic                 msg_ready,
  // dispatch port
  output logic                 dsp_valid,
  output logic [CPU_IDX_W-1:0] dsp_cpu,
  output logic [ADDR_W-1:0]    dsp_addr,
  input  logic                 dsp_ready,
  output logic                 fork_full,
  // memory requests and responses
  input  logic                 mem_valid,
  input  logic                 mem_we,
  input  logic [ADDR_W-1:0]    mem_addr,
  input  logic [DATA_W-1:0]    mem_wdata,
  output logic                 mem_ready,
  output logic                 rsp_valid,
  output logic [DATA_W-1:0]    rsp_rdata,
  input  logic                 rsp_ready
);

  logic                 sched_valid;
  logic [CPU_IDX_W-1:0] sched_cpu;
  logic                 sched_take;
  logic                 thrd_valid;
  logic [ADDR_W-1:0]    thrd_addr;
  logic                 thrd_take;

  // messages are never stalled outside reset
  assign msg_ready = !ext_rst_e;

  cpu_slot_sched sched_i (
    .clk, .ext_rst_e, .msg_valid, .msg_cpu, .msg_code,
    .sched_take, .sched_valid, .sched_cpu
  );

  thread_mngr thrd_i (
    .clk, .ext_rst_e, .msg_valid, .msg_code, .msg_addr,
    .thrd_take, .thrd_valid, .thrd_addr, .fork_full
  );

  dispatch_ctl ctl_i (
    .clk, .ext_rst_e, .sched_valid, .sched_cpu, .sched_take,
    .thrd_valid, .thrd_addr, .thrd_take,
    .dsp_valid, .dsp_cpu, .dsp_addr, .dsp_ready
  );

  mem_server mem_i (
    .clk, .ext_rst_e, .mem_valid, .mem_we, .mem_addr, .mem_wdata,
    .mem_ready, .rsp_valid, .rsp_rdata, .rsp_ready
  );

endmodule

//--- src/mem_server.sv
module mem_server import dispatch_pkg::*; (
  input  logic              clk,
  input  logic              ext_rst_e,
  // request port
  input  logic              mem_valid,
  input  logic              mem_we,
  input  logic [ADDR_W-1:0] mem_addr,
  input  logic [DATA_W-1:0] mem_wdata,
  output logic              mem_ready,
  // read response port
  output logic              rsp_valid,
  output logic [DATA_W-1:0] rsp_rdata,
  input  logic              rsp_ready
);

  logic [DATA_W-1:0] mem [MEM_DEPTH];
  logic [MEM_IDX_W-1:0] word_idx;
  logic accept;

  // upper address bits are ignored
  assign word_idx = mem_addr[MEM_IDX_W-1:0];

  // stall new requests while a response is stuck
  assign mem_ready = !(rsp_valid && !rsp_ready);
  assign accept = mem_valid && mem_ready;

  // array and read data, no reset
  always_ff @(posedge clk) begin
    if (accept && mem_we) begin
      mem[word_idx] <= mem_wdata;
    end
    if (accept && !mem_we) begin
      rsp_rdata <= mem[word_idx];
    end
  end

  // response flag, a write never raises it
  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      rsp_valid <= 1'b0;
    end else if (accept && !mem_we) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  a_rdata_stable: assert property (
    @(posedge clk) disable iff (ext_rst_e)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata)
  );

endmodule

//--- src/thread_mngr.sv
module thread_mngr import dispatch_pkg::*; (
  input  logic              clk,
  input  logic              ext_rst_e,
  // message port, only fork/stop decoded here
  input  logic              msg_valid,
  input  cpu_msg_e          msg_code,
  input  logic [ADDR_W-1:0] msg_addr,
  // handshake towards dispatch_ctl
  input  logic              thrd_take,
  output logic              thrd_valid,
  output logic [ADDR_W-1:0] thrd_addr,
  // fork dropped, table was full
  output logic              fork_full
);

  // thread table: runnable bit plus code address
  logic [THRD_NUM-1:0] thrd_vld;
  logic [ADDR_W-1:0]   thrd_tbl [THRD_NUM];
  logic [THRD_IDX_W-1:0] last_thrd;
  logic [THRD_IDX_W-1:0] free_idx;
  logic [THRD_IDX_W-1:0] pick_idx;
  logic free_found;
  logic fork_req;
  logic stop_req;

  assign fork_req = msg_valid && (msg_code == MSG_FORK);
  assign stop_req = msg_valid && (msg_code == MSG_STOP);

  // lowest free entry
  always_comb begin
    free_found = 1'b0;
    free_idx = '0;
    for (int i = THRD_NUM - 1; i >= 0; i--) begin
      if (!thrd_vld[i]) begin
        free_found = 1'b1;
        free_idx = THRD_IDX_W'(i);
      end
    end
  end

  // runnable bits, fork sets one, stop clears all matches
  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      thrd_vld <= '0;
      fork_full <= 1'b0;
    end else begin
      fork_full <= fork_req && !free_found;
      if (fork_req && free_found) begin
        thrd_vld[free_idx] <= 1'b1;
      end
      if (stop_req) begin
        for (int i = 0; i < THRD_NUM; i++) begin
          // unknown address simply matches nothing
          if (thrd_vld[i] && (thrd_tbl[i] == msg_addr)) begin
            thrd_vld[i] <= 1'b0;
          end
        end
      end
    end
  end

  // address payload
  always_ff @(posedge clk) begin
    if (fork_req && free_found) begin
      thrd_tbl[free_idx] <= msg_addr;
    end
  end

  // round-robin pointer, top index after reset
  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      last_thrd <= THRD_IDX_W'(THRD_NUM - 1);
    end else if (thrd_take) begin
      last_thrd <= pick_idx;
    end
  end

  // same search order as the cpu scheduler
  always_comb begin
    logic [THRD_IDX_W-1:0] idx;
    thrd_valid = 1'b0;
    pick_idx = '0;
    for (int i = THRD_NUM; i >= 1; i--) begin
      idx = last_thrd + THRD_IDX_W'(i);
      if (thrd_vld[idx]) begin
        thrd_valid = 1'b1;
        pick_idx = idx;
      end
    end
  end

  assign thrd_addr = thrd_tbl[pick_idx];

  a_take_needs_valid: assert property (
    @(posedge clk) disable iff (ext_rst_e)
    thrd_take |-> thrd_valid
  );

endmodule

//--- vlog.f
+incdir+include
src/dispatch_pkg.sv
src/cpu_slot_sched.sv
src/thread_mngr.sv
src/dispatch_ctl.sv
src/mem_server.sv
src/dispatcher_of_cpus.sv
dv/tb_dispatcher.sv
